//--- source/qe_macros.svh
// width and synchronizer depth macros for the quadrature encoder channel

`ifndef QE_MACROS_SVH
`define QE_MACROS_SVH

//////////////////////////////////////////////////
// bus widths

// data word on the register bus
`define QE_DATA_W 32

// register address
`define QE_ADDR_W 4

//////////////////////////////////////////////////
// counters and input conditioning

// position and turns counters, signed
`define QE_COUNT_W 32

// flops per encoder line, metastability guard
`define QE_SYNC_STAGES 2

`endif

//--- source/qe_pkg.sv
// qe_pkg: register address, configuration, status and count types

`default_nettype none

`include "qe_macros.svh"

package qe_pkg;

    //////////////////////////////////////////////////
    // register map

    typedef enum logic [`QE_ADDR_W-1:0] {
        ADDR_COUNT  = `QE_ADDR_W'd0,  // position, read/write
        ADDR_TURNS  = `QE_ADDR_W'd1,  // index turns, read only
        ADDR_CONFIG = `QE_ADDR_W'd2,  // configuration, read/write
        ADDR_STATUS = `QE_ADDR_W'd3   // line levels, read only
    } qe_addr_t;

    //////////////////////////////////////////////////
    // register layouts

    // first member is the upper bit
    typedef struct packed {
        logic swap_ab;
        logic index_enable;
    } qe_config_t;

    // synchronized pin levels, before any A/B swap
    typedef struct packed {
        logic line_a;
        logic line_b;
        logic line_i;
    } qe_status_t;

    // position and turns, wraps at the word width
    typedef logic signed [`QE_COUNT_W-1:0] qe_count_t;

endpackage

`default_nettype wire

//--- source/qe_ctr_if.sv
// qe_ctr_if: counter values and position load between bus slave and counters

`timescale 1ns/1ps
`default_nettype none

interface qe_ctr_if;

    import qe_pkg::*;

    // software load of the position counter, one-cycle pulse
    logic      load;
    qe_count_t load_value;

    // live counter values for readback
    qe_count_t position;
    qe_count_t turns;

    // register slave side
    modport bus (
        output load,
        output load_value,
        input  position,
        input  turns
    );

    // counter side
    modport ctr (
        input  load,
        input  load_value,
        output position,
        output turns
    );

endinterface

`default_nettype wire

//--- source/qe_input_sync.sv
// qe_input_sync: encoder line synchronizer with optional A/B swap

`timescale 1ns/1ps
`default_nettype none

`include "qe_macros.svh"

module qe_input_sync (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               enc_a,
    input  wire logic               enc_b,
    input  wire logic               enc_i,
    input  wire logic               swap_ab,
    output logic                    line_a,
    output logic                    line_b,
    output logic                    line_i,
    output qe_pkg::qe_status_t      status
);

    import qe_pkg::*;

    // one row per stage, bits are {a, b, i}
    logic [`QE_SYNC_STAGES-1:0][2:0] chain;
    logic [2:0]                      synced;

    //////////////////////////////////////////////////
    // flop chain

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            chain <= '0;
        end else begin
            chain[0] <= {enc_a, enc_b, enc_i};
            for (int s = 1; s < `QE_SYNC_STAGES; s++) begin
                chain[s] <= chain[s-1];
            end
        end
    end

    assign synced = chain[`QE_SYNC_STAGES-1];

    // status shows the pins as wired
    assign status = qe_status_t'(synced);

    //////////////////////////////////////////////////
    // decoder view, A and B exchanged on request

    assign line_a = swap_ab ? synced[1] : synced[2];
    assign line_b = swap_ab ? synced[2] : synced[1];
    assign line_i = synced[0];

endmodule

`default_nettype wire

//--- source/quadrature_decoder.sv
// quadrature_decoder: Gray step detection, direction and index edge

`timescale 1ns/1ps
`default_nettype none

module quadrature_decoder (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic line_a,
    input  wire logic line_b,
    input  wire logic line_i,
    output logic      step,
    output logic      up,
    output logic      index_edge
);

    logic [1:0] ab_now;
    logic [1:0] ab_prev;
    logic       i_prev;
    logic       fwd;
    logic       bwd;

    // next state when turning forward: 00 -> 10 -> 11 -> 01 -> 00
    function automatic logic [1:0] gray_next(input logic [1:0] ab);
        logic [1:0] nxt;
        case (ab)
            2'b00:   nxt = 2'b10;
            2'b10:   nxt = 2'b11;
            2'b11:   nxt = 2'b01;
            default: nxt = 2'b00;
        endcase
        return nxt;
    endfunction

    assign ab_now = {line_a, line_b};

    // a double change matches neither and is dropped
    assign fwd = (ab_now == gray_next(ab_prev));
    assign bwd = (ab_prev == gray_next(ab_now));

    //////////////////////////////////////////////////
    // event registers

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ab_prev    <= 2'b00;
            i_prev     <= 1'b0;
            step       <= 1'b0;
            up         <= 1'b1;
            index_edge <= 1'b0;
        end else begin
            ab_prev    <= ab_now;
            i_prev     <= line_i;
            step       <= fwd | bwd;
            index_edge <= line_i & ~i_prev;
            // direction sticks until the next valid step
            if (fwd) begin
                up <= 1'b1;
            end else if (bwd) begin
                up <= 1'b0;
            end
        end
    end

    // synchronized pins change at most once per step pulse
    a_step_single: assert property (
        @(posedge clk) disable iff (!reset)
        step |=> !step
    ) else $error("step held high for two cycles");

endmodule

`default_nettype wire

//--- source/position_counters.sv
// position_counters: position counter with software load and index turns counter

`timescale 1ns/1ps
`default_nettype none

module position_counters (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic step,
    input  wire logic up,
    input  wire logic index_edge,
    input  wire logic index_enable,
    qe_ctr_if.ctr     ctr
);

    //////////////////////////////////////////////////
    // position

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ctr.position <= '0;
        end else if (ctr.load) begin
            // software load wins over a step in the same cycle
            ctr.position <= ctr.load_value;
        end else if (step) begin
            if (up) begin
                ctr.position <= ctr.position + 1'b1;
            end else begin
                ctr.position <= ctr.position - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // turns, one per index pulse in the current direction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ctr.turns <= '0;
        end else if (index_edge && index_enable) begin
            if (up) begin
                ctr.turns <= ctr.turns + 1'b1;
            end else begin
                ctr.turns <= ctr.turns - 1'b1;
            end
        end
    end

    // the slave issues one load per write access
    a_load_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        ctr.load |=> !ctr.load
    ) else $error("position load lasted more than one cycle");

endmodule

`default_nettype wire

//--- source/qe_reg_bus.sv
// qe_reg_bus: four-phase register slave, configuration register and read mux

`timescale 1ns/1ps
`default_nettype none

`include "qe_macros.svh"

module qe_reg_bus (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req,
    input  wire logic                   write,
    input  wire qe_pkg::qe_addr_t       addr,
    input  wire logic [`QE_DATA_W-1:0]  wdata,
    input  wire qe_pkg::qe_status_t     status,
    output logic                        ack,
    output logic [`QE_DATA_W-1:0]       rdata,
    output logic                        swap_ab,
    output logic                        index_enable,
    qe_ctr_if.bus                       ctr
);

    import qe_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_RELEASE
    } bus_state_t;

    bus_state_t               state;
    qe_config_t               cfg;
    logic                     accept;
    logic [`QE_DATA_W-1:0]    rd_sel;

    //////////////////////////////////////////////////
    // handshake

    // a request is taken only from idle
    assign accept = (state == ST_IDLE) && req;
    assign ack    = (state == ST_ACK);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // hold ack until the master lets go
                    if (!req) begin
                        state <= ST_RELEASE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // writes

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cfg <= '0;
        end else if (accept && write && (addr == ADDR_CONFIG)) begin
            cfg <= qe_config_t'(wdata[$bits(qe_config_t)-1:0]);
        end
    end

    assign swap_ab      = cfg.swap_ab;
    assign index_enable = cfg.index_enable;

    // position load lands on the edge where ack rises
    assign ctr.load       = accept && write && (addr == ADDR_COUNT);
    assign ctr.load_value = qe_count_t'(wdata[`QE_COUNT_W-1:0]);

    //////////////////////////////////////////////////
    // reads

    always_comb begin
        case (addr)
            ADDR_COUNT:  rd_sel = `QE_DATA_W'(unsigned'(ctr.position));
            ADDR_TURNS:  rd_sel = `QE_DATA_W'(unsigned'(ctr.turns));
            ADDR_CONFIG: rd_sel = `QE_DATA_W'(cfg);
            ADDR_STATUS: rd_sel = `QE_DATA_W'(status);
            default:     rd_sel = '0;
        endcase
    end

    // captured once per access and held while ack is high
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rdata <= '0;
        end else if (accept) begin
            rdata <= rd_sel;
        end
    end

    a_ack_rise: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(ack) |-> $past(req)
    ) else $error("ack raised without a request");

    a_ack_fall: assert property (
        @(posedge clk) disable iff (!reset)
        $fell(ack) |-> $past(!req)
    ) else $error("ack dropped while request still high");

endmodule

`default_nettype wire

//--- source/qe_channel.sv
// qe_channel: quadrature encoder channel top level

`timescale 1ns/1ps
`default_nettype none

`include "qe_macros.svh"

module qe_channel (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   enc_a,
    input  wire logic                   enc_b,
    input  wire logic                   enc_i,
    input  wire logic                   req,
    input  wire logic                   write,
    input  wire logic [`QE_ADDR_W-1:0]  addr,
    input  wire logic [`QE_DATA_W-1:0]  wdata,
    output logic                        ack,
    output logic [`QE_DATA_W-1:0]       rdata
);

    import qe_pkg::*;

    logic       line_a;
    logic       line_b;
    logic       line_i;
    qe_status_t status;
    logic       step;
    logic       up;
    logic       index_edge;
    logic       swap_ab;
    logic       index_enable;

    qe_ctr_if ctr_if ();

    //////////////////////////////////////////////////
    // input side

    qe_input_sync u_input_sync (
        .clk     (clk),
        .reset   (reset),
        .enc_a   (enc_a),
        .enc_b   (enc_b),
        .enc_i   (enc_i),
        .swap_ab (swap_ab),
        .line_a  (line_a),
        .line_b  (line_b),
        .line_i  (line_i),
        .status  (status)
    );

    //////////////////////////////////////////////////
    // decoder and counters

    quadrature_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .line_a     (line_a),
        .line_b     (line_b),
        .line_i     (line_i),
        .step       (step),
        .up         (up),
        .index_edge (index_edge)
    );

    position_counters u_counters (
        .clk          (clk),
        .reset        (reset),
        .step         (step),
        .up           (up),
        .index_edge   (index_edge),
        .index_enable (index_enable),
        .ctr          (ctr_if.ctr)
    );

    //////////////////////////////////////////////////
    // register bus

    qe_reg_bus u_reg_bus (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .write        (write),
        .addr         (qe_addr_t'(addr)),
        .wdata        (wdata),
        .status       (status),
        .ack          (ack),
        .rdata        (rdata),
        .swap_ab      (swap_ab),
        .index_enable (index_enable),
        .ctr          (ctr_if.bus)
    );

endmodule

`default_nettype wire

//--- testbench/tb_qe_channel.sv
// tb_qe_channel: clock, reset, bus tasks, encoder model, protocol assertions and checks

`timescale 1ns/1ps
`default_nettype none

`include "qe_macros.svh"

module tb_qe_channel;

    import qe_pkg::*;

    // settle time after each pin change
    localparam int SETTLE    = 8;
    // about 300 steps of 8 cycles plus bus traffic
    localparam int RUN_LIMIT = 6000;

    logic                   clk;
    logic                   reset;
    logic                   enc_a;
    logic                   enc_b;
    logic                   enc_i;
    logic                   req;
    logic                   write;
    logic [`QE_ADDR_W-1:0]  addr;
    logic [`QE_DATA_W-1:0]  wdata;
    logic                   ack;
    logic [`QE_DATA_W-1:0]  rdata;

    // encoder model
    int                     phase;
    qe_count_t              exp_position;
    qe_count_t              exp_turns;
    logic                   exp_up;
    logic                   swap_set;
    logic                   index_set;
    int                     cycle_count;
    int                     n_fwd;
    int                     n_bwd;
    logic [`QE_DATA_W-1:0]  load_val;
    logic [`QE_DATA_W-1:0]  discard;

    qe_channel UUT (
        .clk   (clk),
        .reset (reset),
        .enc_a (enc_a),
        .enc_b (enc_b),
        .enc_i (enc_i),
        .req   (req),
        .write (write),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            abort_run("run timeout: the tests did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    // forward Gray order on the pins is 00, 10, 11, 01
    function automatic logic [1:0] gray_pins(input int p);
        logic [1:0] seq [4];
        seq = '{2'b00, 2'b10, 2'b11, 2'b01};
        return seq[p & 3];
    endfunction

    task automatic wait_for_ack(input logic level);
        int waited;
        waited = 0;
        while (ack !== level) begin
            @(negedge clk);
            waited++;
            if (waited > 16) begin
                abort_run("bus handshake timeout: ack did not reach the expected level");
            end
        end
    endtask

    task automatic access_reg(input logic wr, input logic [`QE_ADDR_W-1:0] a,
                              input logic [`QE_DATA_W-1:0] d,
                              output logic [`QE_DATA_W-1:0] q);
        @(negedge clk);
        req   = 1'b1;
        write = wr;
        addr  = a;
        wdata = d;
        wait_for_ack(1'b1);
        q   = rdata;
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic expect_reg(input logic [`QE_ADDR_W-1:0] a,
                              input logic [`QE_DATA_W-1:0] exp, input string what);
        logic [`QE_DATA_W-1:0] got;
        access_reg(1'b0, a, '0, got);
        assert (got == exp) else abort_run($sformatf("Fail at %0t: %s read 0x%08h, expected 0x%08h",
                                                     $time, what, got, exp));
    endtask

    task automatic move_pins(input int delta);
        @(negedge clk);
        phase = (phase + delta) & 3;
        {enc_a, enc_b} = gray_pins(phase);
        repeat (SETTLE) @(negedge clk);
    endtask

    // the swap turns a pin step into the opposite count
    task automatic step_pins(input logic forward);
        move_pins(forward ? 1 : -1);
        exp_up = forward ^ swap_set;
        exp_position = exp_up ? exp_position + 1 : exp_position - 1;
    endtask

    task automatic pulse_index;
        @(negedge clk);
        enc_i = 1'b1;
        repeat (SETTLE) @(negedge clk);
        enc_i = 1'b0;
        repeat (SETTLE) @(negedge clk);
        if (index_set) begin
            exp_turns = exp_up ? exp_turns + 1 : exp_turns - 1;
        end
    endtask

    // return the pins to 00 first so that a swap change cannot look like a step
    task automatic write_config(input logic sw, input logic idx);
        logic [`QE_DATA_W-1:0] unused;
        while (phase != 0) begin
            step_pins(1'b1);
        end
        access_reg(1'b1, ADDR_CONFIG, {30'd0, sw, idx}, unused);
        swap_set  = sw;
        index_set = idx;
        expect_reg(ADDR_CONFIG, {30'd0, sw, idx}, "config");
    endtask

    //////////////////////////////////////////////////
    // bus protocol

    a_ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        $rose(ack) |-> $past(req))
        else abort_run($sformatf("Fail at %0t: ack rose without a request", $time));

    a_ack_after_release: assert property (@(posedge clk) disable iff (!reset)
        $fell(ack) |-> $past(!req))
        else abort_run($sformatf("Fail at %0t: ack fell while req was high", $time));

    a_rdata_held: assert property (@(posedge clk) disable iff (!reset)
        (ack && $past(ack)) |-> $stable(rdata))
        else abort_run($sformatf("Fail at %0t: rdata changed while ack was high", $time));

    a_reset_idle: assert property (@(posedge clk) !reset |-> (!ack && rdata == '0))
        else abort_run($sformatf("Fail at %0t: bus outputs active during reset", $time));

    //////////////////////////////////////////////////
    // tests

    initial begin
        {enc_a, enc_b, enc_i} = 3'b000;
        {req, write, addr, wdata} = '0;
        reset = 1'b0;
        cycle_count = 0;
        {phase, exp_position, exp_turns} = '0;
        {exp_up, swap_set, index_set} = 3'b100;
        void'($urandom(68));
        repeat (8) @(negedge clk);
        reset = 1'b1;

        // after reset
        assert (ack == 1'b0) else abort_run($sformatf("Fail at %0t: ack high after reset", $time));
        expect_reg(ADDR_COUNT, '0, "position after reset");
        expect_reg(ADDR_TURNS, '0, "turns after reset");
        expect_reg(ADDR_CONFIG, '0, "config after reset");
        expect_reg(4'd9, '0, "unmapped address");

        // forward, a missed step, then backward
        n_fwd = $urandom_range(40, 1);
        n_bwd = $urandom_range(40, 1);
        repeat (n_fwd) step_pins(1'b1);
        expect_reg(ADDR_COUNT, exp_position, "position after forward steps");
        move_pins(2);
        expect_reg(ADDR_COUNT, exp_position, "position after double change");
        repeat (n_bwd) step_pins(1'b0);
        expect_reg(ADDR_COUNT, n_fwd - n_bwd, "position after backward steps");

        // swapped lines count the other way
        write_config(1'b1, 1'b0);
        repeat ($urandom_range(20, 1)) step_pins(1'b1);
        expect_reg(ADDR_COUNT, exp_position, "position with swap");
        write_config(1'b0, 1'b0);

        // index pulses ignored first and then counted by direction
        repeat (3) pulse_index();
        expect_reg(ADDR_TURNS, exp_turns, "turns with index disabled");
        write_config(1'b0, 1'b1);
        repeat (3) step_pins(1'b1);
        pulse_index();
        repeat (2) step_pins(1'b0);
        repeat (2) pulse_index();
        expect_reg(ADDR_TURNS, exp_turns, "turns with index enabled");
        access_reg(1'b1, ADDR_TURNS, $urandom(), discard);
        expect_reg(ADDR_TURNS, exp_turns, "turns after write to read-only register");

        // software load, then two steps
        load_val = $urandom();
        access_reg(1'b1, ADDR_COUNT, load_val, discard);
        exp_position = load_val;
        repeat (2) step_pins(1'b1);
        expect_reg(ADDR_COUNT, load_val + 2, "position after load");

        // pin levels in status are not affected by the swap
        for (int sw = 0; sw < 2; sw++) begin
            write_config(sw[0], 1'b0);
            for (int lvl = 0; lvl < 8; lvl++) begin
                @(negedge clk);
                {enc_a, enc_b, enc_i} = lvl[2:0];
                repeat (SETTLE) @(negedge clk);
                expect_reg(ADDR_STATUS, lvl, "status");
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- qe_channel.f
+incdir+source
source/qe_pkg.sv
source/qe_ctr_if.sv
source/qe_input_sync.sv
source/quadrature_decoder.sv
source/position_counters.sv
source/qe_reg_bus.sv
source/qe_channel.sv
testbench/tb_qe_channel.sv

//--- Bender.yml
package:
  name: qe_channel

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/qe_pkg.sv
      - source/qe_ctr_if.sv
      - source/qe_input_sync.sv
      - source/quadrature_decoder.sv
      - source/position_counters.sv
      - source/qe_reg_bus.sv
      - source/qe_channel.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_qe_channel.sv
